//--- rtl/ipv4_tx_pkg.sv
package ipv4_tx_pkg;

  // fixed header, no options.
  localparam int IPV4_HDR_LEN = 20;

  localparam int ARP_ENTRIES = 8;

  // adder tree depth for 16 padded header words.
  localparam int CKS_LEVELS = 4;

  localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;

  // wishbone register map.
  typedef enum logic [4:0] {
    REG_LOCAL_IP     = 5'd0,
    REG_LOCAL_MAC_HI = 5'd1,
    REG_LOCAL_MAC_LO = 5'd2,
    REG_ENTRY_IP     = 5'd3,
    REG_ENTRY_MAC_HI = 5'd4,
    REG_ENTRY_MAC_LO = 5'd5,
    REG_ENTRY_COMMIT = 5'd6
  } wb_reg_e;

  // transmit sequence of one datagram.
  typedef enum logic [2:0] {
    IDLE,
    WAIT_RES,
    READY,
    HEADER,
    PAYLOAD,
    DONE
  } framer_state_e;

endpackage

//--- rtl/addr_resolver.sv
`timescale 1ns/10ps

module addr_resolver (
  input  logic        clk,
  input  logic        fsm_rst,
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  logic [4:0]  wb_adr,
  input  logic [31:0] wb_dat_w,
  input  logic        lookup_start,
  input  logic [31:0] lookup_ip,
  output logic        wb_ack,
  output logic [31:0] wb_dat_r,
  output logic [31:0] local_ip,
  output logic [47:0] local_mac,
  output logic        res_val,
  output logic        res_miss,
  output logic [47:0] res_mac
);

  localparam int IDX_W = $clog2(ipv4_tx_pkg::ARP_ENTRIES);

  ipv4_tx_pkg::wb_reg_e reg_sel;
  logic                 wb_wr;
  logic [IDX_W-1:0]     commit_idx;
  logic [31:0]          rd_data;
  logic [31:0]          stg_ip;
  logic [47:0]          stg_mac;
  logic [31:0]          ent_ip  [ipv4_tx_pkg::ARP_ENTRIES];
  logic [47:0]          ent_mac [ipv4_tx_pkg::ARP_ENTRIES];
  logic [ipv4_tx_pkg::ARP_ENTRIES-1:0] ent_vld;
  logic                 searching;
  logic [31:0]          srch_ip;
  logic [IDX_W-1:0]     idx;
  logic                 ent_hit;
  logic                 last_idx;
  logic                 is_bcast;

  assign reg_sel    = ipv4_tx_pkg::wb_reg_e'(wb_adr);
  // write once per access, on the cycle before ack.
  assign wb_wr      = wb_cyc && wb_stb && wb_we && !wb_ack;
  assign commit_idx = wb_dat_w[IDX_W-1:0];

  always_comb begin
    case (reg_sel)
      ipv4_tx_pkg::REG_LOCAL_IP:     rd_data = local_ip;
      ipv4_tx_pkg::REG_LOCAL_MAC_HI: rd_data = {16'h0000, local_mac[47:32]};
      ipv4_tx_pkg::REG_LOCAL_MAC_LO: rd_data = local_mac[31:0];
      ipv4_tx_pkg::REG_ENTRY_IP:     rd_data = stg_ip;
      ipv4_tx_pkg::REG_ENTRY_MAC_HI: rd_data = {16'h0000, stg_mac[47:32]};
      ipv4_tx_pkg::REG_ENTRY_MAC_LO: rd_data = stg_mac[31:0];
      default:                       rd_data = 32'h0000_0000;
    endcase
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      wb_ack    <= 1'b0;
      local_ip  <= '0;
      local_mac <= '0;
      ent_vld   <= '0;
    end else begin
      wb_ack <= wb_cyc && wb_stb && !wb_ack;
      if (wb_wr) begin
        case (reg_sel)
          ipv4_tx_pkg::REG_LOCAL_IP:     local_ip <= wb_dat_w;
          ipv4_tx_pkg::REG_LOCAL_MAC_HI: local_mac[47:32] <= wb_dat_w[15:0];
          ipv4_tx_pkg::REG_LOCAL_MAC_LO: local_mac[31:0] <= wb_dat_w;
          ipv4_tx_pkg::REG_ENTRY_COMMIT: ent_vld[commit_idx] <= 1'b1;
          default: ;
        endcase
      end
    end
  end

  // staging and table contents.
  always_ff @(posedge clk) begin
    if (wb_wr) begin
      case (reg_sel)
        ipv4_tx_pkg::REG_ENTRY_IP:     stg_ip <= wb_dat_w;
        ipv4_tx_pkg::REG_ENTRY_MAC_HI: stg_mac[47:32] <= wb_dat_w[15:0];
        ipv4_tx_pkg::REG_ENTRY_MAC_LO: stg_mac[31:0] <= wb_dat_w;
        ipv4_tx_pkg::REG_ENTRY_COMMIT: begin
          ent_ip[commit_idx]  <= stg_ip;
          ent_mac[commit_idx] <= stg_mac;
        end
        default: ;
      endcase
    end
    if (wb_cyc && wb_stb) begin
      wb_dat_r <= rd_data;
    end
  end

  assign is_bcast = (lookup_ip == 32'hffff_ffff);
  assign ent_hit  = ent_vld[idx] && (ent_ip[idx] == srch_ip);
  assign last_idx = (idx == IDX_W'(ipv4_tx_pkg::ARP_ENTRIES - 1));

  // one entry per cycle, first valid match wins.
  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      searching <= 1'b0;
      res_val   <= 1'b0;
      res_miss  <= 1'b0;
    end else begin
      res_val  <= 1'b0;
      res_miss <= 1'b0;
      if (lookup_start) begin
        searching <= !is_bcast;
        res_val   <= is_bcast;
      end else if (searching) begin
        if (ent_hit) begin
          res_val   <= 1'b1;
          searching <= 1'b0;
        end else if (last_idx) begin
          res_miss  <= 1'b1;
          searching <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (lookup_start) begin
      srch_ip <= lookup_ip;
      idx     <= '0;
      res_mac <= '1;
    end else if (searching) begin
      idx <= idx + 1'b1;
      if (ent_hit) begin
        res_mac <= ent_mac[idx];
      end
    end
  end

  assert property (@(posedge clk) disable iff (fsm_rst) wb_ack |-> wb_cyc && wb_stb);
  assert property (@(posedge clk) disable iff (fsm_rst) !(res_val && res_miss));

endmodule

//--- rtl/ipv4_cks_calc.sv
`timescale 1ns/10ps

module ipv4_cks_calc (
  input  logic        clk,
  input  logic        fsm_rst,
  input  logic        cks_start,
  input  logic [31:0] local_ip,
  input  logic [31:0] dst_ip,
  input  logic [7:0]  proto,
  input  logic [7:0]  ttl,
  input  logic [15:0] ip_id,
  input  logic [15:0] total_len,
  output logic        cks_val,
  output logic [15:0] cks
);

  localparam int WORDS = 2 ** ipv4_tx_pkg::CKS_LEVELS;
  localparam int HDR_WORDS = ipv4_tx_pkg::IPV4_HDR_LEN / 2;

  logic [19:0] tree [ipv4_tx_pkg::CKS_LEVELS+1][WORDS];
  logic [15:0] hdr_w [WORDS];
  logic [ipv4_tx_pkg::CKS_LEVELS:1] vld_q;
  logic [19:0] sum;
  logic [16:0] fold1;
  logic [16:0] fold2;

  // header words, checksum field as zero.
  always_comb begin
    for (int i = 0; i < WORDS; i++) begin
      hdr_w[i] = 16'h0000;
    end
    hdr_w[0] = 16'h4500;
    hdr_w[1] = total_len;
    hdr_w[2] = ip_id;
    hdr_w[3] = 16'h4000;
    hdr_w[4] = {ttl, proto};
    hdr_w[5] = 16'h0000;
    hdr_w[6] = local_ip[31:16];
    hdr_w[7] = local_ip[15:0];
    hdr_w[8] = dst_ip[31:16];
    hdr_w[HDR_WORDS-1] = dst_ip[15:0];
  end

  for (genvar i = 0; i < WORDS; i++) begin : g_in
    assign tree[0][i] = {4'h0, hdr_w[i]};
  end

  // each level halves the number of partial sums.
  for (genvar l = 1; l <= ipv4_tx_pkg::CKS_LEVELS; l++) begin : g_lvl
    for (genvar i = 0; i < WORDS; i++) begin : g_node
      if (i < (WORDS >> l)) begin : g_add
        always_ff @(posedge clk) begin
          tree[l][i] <= tree[l-1][2*i] + tree[l-1][2*i+1];
        end
      end else begin : g_pad
        assign tree[l][i] = '0;
      end
    end
  end

  assign sum   = tree[ipv4_tx_pkg::CKS_LEVELS][0];
  assign fold1 = {1'b0, sum[15:0]} + {13'h0000, sum[19:16]};
  assign fold2 = {1'b0, fold1[15:0]} + {16'h0000, fold1[16]};

  always_ff @(posedge clk) begin
    cks <= ~fold2[15:0];
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      vld_q   <= '0;
      cks_val <= 1'b0;
    end else begin
      vld_q   <= {vld_q[ipv4_tx_pkg::CKS_LEVELS-1:1], cks_start};
      cks_val <= vld_q[ipv4_tx_pkg::CKS_LEVELS];
    end
  end

endmodule

//--- rtl/ipv4_tx_framer.sv
`timescale 1ns/10ps

module ipv4_tx_framer (
  input  logic        clk,
  input  logic        fsm_rst,
  input  logic        tx_start,
  input  logic [31:0] dst_ip,
  input  logic [7:0]  proto,
  input  logic [7:0]  ttl,
  input  logic [15:0] ip_id,
  input  logic [15:0] pld_len,
  input  logic [31:0] local_ip,
  input  logic [47:0] local_mac,
  input  logic        res_val,
  input  logic        res_miss,
  input  logic [47:0] res_mac,
  input  logic        cks_val,
  input  logic [15:0] cks,
  input  logic        mac_req,
  input  logic [7:0]  pld_dat,
  output logic        tx_busy,
  output logic        tx_done,
  output logic        tx_err,
  output logic        lookup_start,
  output logic [31:0] lookup_ip,
  output logic        cks_start,
  output logic [15:0] total_len,
  output logic        frame_rdy,
  output logic [47:0] eth_dst_mac,
  output logic [47:0] eth_src_mac,
  output logic [15:0] frame_len,
  output logic        out_val,
  output logic        out_sof,
  output logic        out_eof,
  output logic [7:0]  out_dat,
  output logic        pld_rd
);

  localparam int HDR = ipv4_tx_pkg::IPV4_HDR_LEN;

  ipv4_tx_pkg::framer_state_e state;
  logic                 accept;
  logic [HDR-1:0][7:0]  hdr;
  logic [15:0]          cnt;
  logic [15:0]          cnt_nxt;
  logic                 shift_en;
  logic                 last;
  logic                 rd_next;
  logic                 got_mac;
  logic                 got_miss;
  logic                 got_cks;
  logic                 mac_ok;
  logic                 miss_ok;
  logic                 cks_ok;

  assign accept       = tx_start && (state == ipv4_tx_pkg::IDLE);
  // resolver and checksum start on the accept cycle itself.
  assign lookup_start = accept;
  assign cks_start    = accept;
  assign lookup_ip    = dst_ip;
  assign total_len    = pld_len + 16'(HDR);

  assign mac_ok  = got_mac || res_val;
  assign miss_ok = got_miss || res_miss;
  assign cks_ok  = got_cks || cks_val;

  assign shift_en = (state == ipv4_tx_pkg::READY && mac_req) ||
                    state == ipv4_tx_pkg::HEADER || state == ipv4_tx_pkg::PAYLOAD;
  assign cnt_nxt  = (state == ipv4_tx_pkg::READY) ? 16'd1 : cnt + 16'd1;
  assign last     = (cnt_nxt == frame_len);
  // read one cycle early so payload follows the header directly.
  assign rd_next  = (cnt_nxt >= 16'(HDR - 1)) && (cnt_nxt < frame_len - 16'd1);

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state     <= ipv4_tx_pkg::IDLE;
      tx_busy   <= 1'b0;
      tx_done   <= 1'b0;
      tx_err    <= 1'b0;
      frame_rdy <= 1'b0;
      out_val   <= 1'b0;
      out_sof   <= 1'b0;
      out_eof   <= 1'b0;
      pld_rd    <= 1'b0;
      got_mac   <= 1'b0;
      got_miss  <= 1'b0;
      got_cks   <= 1'b0;
    end else begin
      tx_done <= 1'b0;
      tx_err  <= 1'b0;
      pld_rd  <= 1'b0;
      case (state)
        ipv4_tx_pkg::IDLE: begin
          got_mac  <= 1'b0;
          got_miss <= 1'b0;
          got_cks  <= 1'b0;
          if (accept) begin
            tx_busy <= 1'b1;
            state   <= ipv4_tx_pkg::WAIT_RES;
          end
        end
        ipv4_tx_pkg::WAIT_RES: begin
          got_mac  <= mac_ok;
          got_miss <= miss_ok;
          got_cks  <= cks_ok;
          if (cks_ok && mac_ok) begin
            frame_rdy <= 1'b1;
            state     <= ipv4_tx_pkg::READY;
          end else if (cks_ok && miss_ok) begin
            tx_err  <= 1'b1;
            tx_busy <= 1'b0;
            state   <= ipv4_tx_pkg::IDLE;
          end
        end
        ipv4_tx_pkg::READY: begin
          if (mac_req) begin
            frame_rdy <= 1'b0;
            out_val   <= 1'b1;
            out_sof   <= 1'b1;
            state     <= ipv4_tx_pkg::HEADER;
          end
        end
        ipv4_tx_pkg::HEADER: begin
          out_sof <= 1'b0;
          out_eof <= last;
          pld_rd  <= rd_next;
          if (cnt_nxt == 16'(HDR)) begin
            state <= last ? ipv4_tx_pkg::DONE : ipv4_tx_pkg::PAYLOAD;
          end
        end
        ipv4_tx_pkg::PAYLOAD: begin
          out_eof <= last;
          pld_rd  <= rd_next;
          if (last) begin
            state <= ipv4_tx_pkg::DONE;
          end
        end
        ipv4_tx_pkg::DONE: begin
          out_val <= 1'b0;
          out_eof <= 1'b0;
          tx_done <= 1'b1;
          tx_busy <= 1'b0;
          state   <= ipv4_tx_pkg::IDLE;
        end
        default: state <= ipv4_tx_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      hdr <= {8'h45, 8'h00, total_len, ip_id, 16'h4000, ttl, proto, 16'h0000,
              local_ip, dst_ip};
      frame_len   <= total_len;
      eth_src_mac <= local_mac;
    end
    if (res_val) begin
      eth_dst_mac <= res_mac;
    end
    if (cks_val) begin
      hdr[9:8] <= cks;
    end
    if (shift_en) begin
      hdr     <= {hdr[HDR-2:0], 8'h00};
      cnt     <= cnt_nxt;
      out_dat <= (state == ipv4_tx_pkg::PAYLOAD) ? pld_dat : hdr[HDR-1];
    end
  end

  assert property (@(posedge clk) disable iff (fsm_rst) (out_sof || out_eof) |-> out_val);

  // sum arrives while the request still waits for the resolver.
  assert property (@(posedge clk) disable iff (fsm_rst)
    cks_start |-> ##(ipv4_tx_pkg::CKS_LEVELS + 1) cks_val);
  assert property (@(posedge clk) disable iff (fsm_rst)
    cks_val |-> state == ipv4_tx_pkg::WAIT_RES);

endmodule

//--- rtl/ipv4_tx_top.sv
`timescale 1ns/10ps

module ipv4_tx_top (
  input  logic        clk,
  input  logic        fsm_rst,
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  logic [4:0]  wb_adr,
  input  logic [31:0] wb_dat_w,
  input  logic        tx_start,
  input  logic [31:0] dst_ip,
  input  logic [7:0]  proto,
  input  logic [7:0]  ttl,
  input  logic [15:0] ip_id,
  input  logic [15:0] pld_len,
  input  logic        mac_req,
  input  logic [7:0]  pld_dat,
  output logic        wb_ack,
  output logic [31:0] wb_dat_r,
  output logic        tx_busy,
  output logic        tx_done,
  output logic        tx_err,
  output logic        frame_rdy,
  output logic [47:0] eth_dst_mac,
  output logic [47:0] eth_src_mac,
  output logic [15:0] frame_len,
  output logic        out_val,
  output logic        out_sof,
  output logic        out_eof,
  output logic [7:0]  out_dat,
  output logic        pld_rd
);

  logic [31:0] local_ip;
  logic [47:0] local_mac;
  logic        lookup_start;
  logic [31:0] lookup_ip;
  logic        res_val;
  logic        res_miss;
  logic [47:0] res_mac;
  logic        cks_start;
  logic [15:0] total_len;
  logic        cks_val;
  logic [15:0] cks;

  addr_resolver u_resolver (
    .clk          (clk),
    .fsm_rst      (fsm_rst),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_we        (wb_we),
    .wb_adr       (wb_adr),
    .wb_dat_w     (wb_dat_w),
    .lookup_start (lookup_start),
    .lookup_ip    (lookup_ip),
    .wb_ack       (wb_ack),
    .wb_dat_r     (wb_dat_r),
    .local_ip     (local_ip),
    .local_mac    (local_mac),
    .res_val      (res_val),
    .res_miss     (res_miss),
    .res_mac      (res_mac)
  );

  // raw request fields are valid on the cks_start cycle.
  ipv4_cks_calc u_cks (
    .clk       (clk),
    .fsm_rst   (fsm_rst),
    .cks_start (cks_start),
    .local_ip  (local_ip),
    .dst_ip    (dst_ip),
    .proto     (proto),
    .ttl       (ttl),
    .ip_id     (ip_id),
    .total_len (total_len),
    .cks_val   (cks_val),
    .cks       (cks)
  );

  ipv4_tx_framer u_framer (
    .clk          (clk),
    .fsm_rst      (fsm_rst),
    .tx_start     (tx_start),
    .dst_ip       (dst_ip),
    .proto        (proto),
    .ttl          (ttl),
    .ip_id        (ip_id),
    .pld_len      (pld_len),
    .local_ip     (local_ip),
    .local_mac    (local_mac),
    .res_val      (res_val),
    .res_miss     (res_miss),
    .res_mac      (res_mac),
    .cks_val      (cks_val),
    .cks          (cks),
    .mac_req      (mac_req),
    .pld_dat      (pld_dat),
    .tx_busy      (tx_busy),
    .tx_done      (tx_done),
    .tx_err       (tx_err),
    .lookup_start (lookup_start),
    .lookup_ip    (lookup_ip),
    .cks_start    (cks_start),
    .total_len    (total_len),
    .frame_rdy    (frame_rdy),
    .eth_dst_mac  (eth_dst_mac),
    .eth_src_mac  (eth_src_mac),
    .frame_len    (frame_len),
    .out_val      (out_val),
    .out_sof      (out_sof),
    .out_eof      (out_eof),
    .out_dat      (out_dat),
    .pld_rd       (pld_rd)
  );

endmodule

//--- verification/ipv4_tx_tb.sv
`timescale 1ns/10ps

module ipv4_tx_tb;

  localparam logic [4:0] ADR_LOCAL_IP = 5'd0;
  localparam logic [4:0] ADR_MAC_HI   = 5'd1;
  localparam logic [4:0] ADR_MAC_LO   = 5'd2;
  localparam logic [4:0] ADR_ENT_IP   = 5'd3;
  localparam logic [4:0] ADR_ENT_HI   = 5'd4;
  localparam logic [4:0] ADR_ENT_LO   = 5'd5;
  localparam logic [4:0] ADR_COMMIT   = 5'd6;
  localparam string CASES_FILE = "verification/ipv4_tx_cases.txt";

  logic        clk;
  logic        fsm_rst;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [4:0]  wb_adr;
  logic [31:0] wb_dat_w;
  logic        tx_start;
  logic [31:0] dst_ip;
  logic [7:0]  proto;
  logic [7:0]  ttl;
  logic [15:0] ip_id;
  logic [15:0] pld_len;
  logic        mac_req;
  logic [7:0]  pld_dat;
  logic        wb_ack;
  logic [31:0] wb_dat_r;
  logic        tx_busy;
  logic        tx_done;
  logic        tx_err;
  logic        frame_rdy;
  logic [47:0] eth_dst_mac;
  logic [47:0] eth_src_mac;
  logic [15:0] frame_len;
  logic        out_val;
  logic        out_sof;
  logic        out_eof;
  logic [7:0]  out_dat;
  logic        pld_rd;

  // reference copy of the register file.
  logic [31:0] m_local_ip;
  logic [47:0] m_local_mac;
  logic [31:0] m_stg_ip;
  logic [47:0] m_stg_mac;
  logic [31:0] m_ent_ip [8];
  logic [47:0] m_ent_mac [8];
  logic [7:0]  m_ent_vld;

  byte         kind_q [$];
  logic [31:0] a_q [$];
  logic [31:0] b_q [$];
  logic [31:0] c_q [$];
  logic [31:0] d_q [$];
  logic [31:0] e_q [$];
  string       res_q [$];

  logic [31:0] lfsr;
  logic [7:0]  pld_sent [$];
  logic [7:0]  feed_byte;
  logic        feed_pend;
  int          errors;
  int          n_pass;
  int          n_fail;
  int          cycles;
  int          limit;
  logic        counting;
  logic [31:0] rdat;
  logic        acked;

  ipv4_tx_top u_dut (
    .clk (clk), .fsm_rst (fsm_rst),
    .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we), .wb_adr (wb_adr),
    .wb_dat_w (wb_dat_w), .tx_start (tx_start), .dst_ip (dst_ip), .proto (proto),
    .ttl (ttl), .ip_id (ip_id), .pld_len (pld_len), .mac_req (mac_req),
    .pld_dat (pld_dat), .wb_ack (wb_ack), .wb_dat_r (wb_dat_r), .tx_busy (tx_busy),
    .tx_done (tx_done), .tx_err (tx_err), .frame_rdy (frame_rdy),
    .eth_dst_mac (eth_dst_mac), .eth_src_mac (eth_src_mac), .frame_len (frame_len),
    .out_val (out_val), .out_sof (out_sof), .out_eof (out_eof), .out_dat (out_dat),
    .pld_rd (pld_rd)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    // taps 32, 22, 2, 1.
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_pld_byte(output logic [7:0] b);
    b = 8'h00;
    for (int i = 0; i < 8; i++) begin
      lfsr = lfsr_step(lfsr);
      b = {b[6:0], lfsr[0]};
    end
  endtask

  // answer each pld_rd with the next byte one cycle later.
  always @(negedge clk) begin
    if (pld_rd === 1'b1) begin
      take_pld_byte(feed_byte);
      pld_sent.push_back(feed_byte);
      feed_pend = 1'b1;
    end else begin
      feed_pend = 1'b0;
    end
  end

  always @(posedge clk) begin
    if (feed_pend) begin
      pld_dat <= feed_byte;
    end
  end

  always @(posedge clk) begin
    if (counting) begin
      cycles = cycles + 1;
      if (cycles > limit) begin
        $display("timeout: the run did not finish within %0d cycles", limit);
        $display("Simulation failed");
        $finish;
      end
    end
  end

  task automatic report_value(input string what, input logic [63:0] got,
                              input logic [63:0] exp);
    $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
    errors++;
  endtask

  task automatic report_problem(input string what);
    $display("problem at %0t: %s", $time, what);
    errors++;
  endtask

  task automatic model_write(input logic [4:0] adr, input logic [31:0] dat);
    case (adr)
      ADR_LOCAL_IP: m_local_ip = dat;
      ADR_MAC_HI:   m_local_mac[47:32] = dat[15:0];
      ADR_MAC_LO:   m_local_mac[31:0] = dat;
      ADR_ENT_IP:   m_stg_ip = dat;
      ADR_ENT_HI:   m_stg_mac[47:32] = dat[15:0];
      ADR_ENT_LO:   m_stg_mac[31:0] = dat;
      ADR_COMMIT: begin
        m_ent_ip[dat[2:0]]  = m_stg_ip;
        m_ent_mac[dat[2:0]] = m_stg_mac;
        m_ent_vld[dat[2:0]] = 1'b1;
      end
      default: ;
    endcase
  endtask

  // lowest valid index wins.
  task automatic model_lookup(input logic [31:0] ip, output logic found,
                              output logic [47:0] mac);
    found = 1'b0;
    mac = '1;
    for (int i = 7; i >= 0; i--) begin
      if (m_ent_vld[i] && m_ent_ip[i] == ip) begin
        found = 1'b1;
        mac = m_ent_mac[i];
      end
    end
  endtask

  function automatic logic [15:0] hdr_checksum(input logic [7:0] h [20]);
    logic [31:0] acc;
    acc = 32'h0;
    for (int i = 0; i < 20; i += 2) begin
      acc = acc + {16'h0000, h[i], h[i+1]};
    end
    while (acc[31:16] != 16'h0000) begin
      acc = {16'h0000, acc[15:0]} + {16'h0000, acc[31:16]};
    end
    return ~acc[15:0];
  endfunction

  task automatic wb_access(input logic we, input logic [4:0] adr, input logic [31:0] dat,
                           output logic [31:0] rd, output logic ack_seen);
    int waited;
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= dat;
    waited   = 0;
    ack_seen = 1'b0;
    rd       = '0;
    while (!ack_seen && waited < 3) begin
      @(negedge clk);
      waited++;
      if (wb_ack === 1'b1) begin
        ack_seen = 1'b1;
        rd = wb_dat_r;
      end
    end
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic load_cases();
    int fd;
    int rc;
    string line;
    string res;
    logic [31:0] v0;
    logic [31:0] v1;
    logic [31:0] v2;
    logic [31:0] v3;
    logic [31:0] v4;
    fd = $fopen(CASES_FILE, "r");
    if (fd == 0) begin
      $display("cannot open the case file %s", CASES_FILE);
      $display("Simulation failed");
      $finish;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        res = "";
        v2 = '0;
        v3 = '0;
        v4 = '0;
        rc = $fgets(line, fd);
        if (rc > 1 && (line[0] == "W" || line[0] == "R" || line[0] == "T")) begin
          if (line[0] == "T") begin
            rc = $sscanf(line, "T %h %h %h %h %h %s", v0, v1, v2, v3, v4, res);
            limit += int'(v4[15:0]) + 20 + 40;
          end else if (line[0] == "W") begin
            rc = $sscanf(line, "W %h %h", v0, v1);
            limit += 4;
          end else begin
            rc = $sscanf(line, "R %h %h", v0, v1);
            limit += 4;
          end
          kind_q.push_back(line[0]);
          a_q.push_back(v0);
          b_q.push_back(v1);
          c_q.push_back(v2);
          d_q.push_back(v3);
          e_q.push_back(v4);
          res_q.push_back(res);
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic check_reset_values();
    logic [11:0] outs;
    outs = {tx_busy, frame_rdy, out_val, out_sof, out_eof, pld_rd, tx_done, tx_err,
            wb_ack, u_dut.res_val, u_dut.res_miss, u_dut.cks_val};
    assert (outs === 12'h000) else report_value("outputs under reset", outs, 0);
  endtask

  task automatic run_datagram(input logic [31:0] dst, input logic [7:0] prt,
                              input logic [7:0] tl, input logic [15:0] id,
                              input logic [15:0] len, input string kind);
    logic [7:0]  hdr [20];
    logic [47:0] exp_dst;
    logic [15:0] flen;
    logic [15:0] cks_exp;
    logic [7:0]  exp_b;
    logic        found;
    logic        seen_rdy;
    logic        seen_err;
    int          waited;
    pld_sent.delete();
    flen = len + 16'd20;
    @(posedge clk);
    tx_start <= 1'b1;
    dst_ip   <= dst;
    proto    <= prt;
    ttl      <= tl;
    ip_id    <= id;
    pld_len  <= len;
    @(posedge clk);
    tx_start <= 1'b0;
    @(negedge clk);
    assert (tx_busy === 1'b1) else report_value("tx_busy after start", tx_busy, 1);
    waited = 0;
    while (frame_rdy !== 1'b1 && tx_err !== 1'b1 && waited < 30) begin
      @(negedge clk);
      waited++;
    end
    seen_rdy = (frame_rdy === 1'b1);
    seen_err = (tx_err === 1'b1);
    if (kind == "miss") begin
      assert (seen_err) else report_problem("no tx_err came for a table miss");
      assert (!seen_rdy) else report_problem("frame_rdy came for a table miss");
      assert (tx_busy === 1'b0) else report_value("tx_busy with tx_err", tx_busy, 0);
      repeat (3) begin
        @(negedge clk);
        assert (frame_rdy !== 1'b1 && out_val !== 1'b1)
          else report_problem("a frame started after a miss");
      end
      return;
    end
    if (kind == "broadcast") begin
      exp_dst = '1;
    end else begin
      model_lookup(dst, found, exp_dst);
      assert (found) else report_problem("hit expected but the model table has no entry");
    end
    assert (seen_rdy) else report_problem("frame_rdy never came");
    if (!seen_rdy) begin
      return;
    end
    assert (eth_dst_mac === exp_dst) else report_value("eth_dst_mac", eth_dst_mac, exp_dst);
    assert (eth_src_mac === m_local_mac)
      else report_value("eth_src_mac", eth_src_mac, m_local_mac);
    assert (frame_len === flen) else report_value("frame_len", frame_len, flen);
    hdr[0]  = 8'h45;
    hdr[1]  = 8'h00;
    hdr[2]  = flen[15:8];
    hdr[3]  = flen[7:0];
    hdr[4]  = id[15:8];
    hdr[5]  = id[7:0];
    // DF set, no fragment offset.
    hdr[6]  = 8'h40;
    hdr[7]  = 8'h00;
    hdr[8]  = tl;
    hdr[9]  = prt;
    hdr[10] = 8'h00;
    hdr[11] = 8'h00;
    for (int i = 0; i < 4; i++) begin
      hdr[12+i] = m_local_ip[31-8*i -: 8];
      hdr[16+i] = dst[31-8*i -: 8];
    end
    cks_exp = hdr_checksum(hdr);
    hdr[10] = cks_exp[15:8];
    hdr[11] = cks_exp[7:0];
    @(posedge clk);
    mac_req <= 1'b1;
    @(posedge clk);
    mac_req <= 1'b0;
    for (int k = 0; k < int'(flen); k++) begin
      @(negedge clk);
      if (k == 0) begin
        assert (frame_rdy === 1'b0) else report_value("frame_rdy after mac_req", frame_rdy, 0);
      end
      assert (out_val === 1'b1) else report_problem($sformatf("out_val low at byte %0d", k));
      assert (out_sof === (k == 0)) else report_value($sformatf("out_sof at byte %0d", k),
                                                      out_sof, (k == 0));
      assert (out_eof === (k == int'(flen) - 1))
        else report_value($sformatf("out_eof at byte %0d", k), out_eof, (k == int'(flen) - 1));
      if (k < 20) begin
        exp_b = hdr[k];
      end else if (k - 20 < pld_sent.size()) begin
        exp_b = pld_sent[k-20];
      end else begin
        exp_b = 8'h00;
        report_problem($sformatf("payload byte %0d went out without a pld_rd", k - 20));
      end
      assert (out_dat === exp_b) else report_value($sformatf("out_dat byte %0d", k),
                                                   out_dat, exp_b);
    end
    @(negedge clk);
    assert (tx_done === 1'b1) else report_problem("tx_done did not follow out_eof");
    assert (out_val === 1'b0) else report_problem("out_val stayed high after the frame");
    assert (tx_busy === 1'b0) else report_value("tx_busy after tx_done", tx_busy, 0);
    assert (pld_sent.size() == int'(len))
      else report_value("pld_rd pulses", pld_sent.size(), len);
  endtask

  initial begin
    fsm_rst  = 1'b1;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    tx_start = 1'b0;
    dst_ip   = '0;
    proto    = '0;
    ttl      = '0;
    ip_id    = '0;
    pld_len  = '0;
    mac_req  = 1'b0;
    pld_dat  = '0;
    feed_pend = 1'b0;
    lfsr     = 32'hf78deb8f;
    m_local_ip  = '0;
    m_local_mac = '0;
    m_stg_ip    = '0;
    m_stg_mac   = '0;
    m_ent_vld   = '0;
    errors   = 0;
    n_pass   = 0;
    n_fail   = 0;
    cycles   = 0;
    limit    = 0;
    counting = 1'b0;
    load_cases();
    repeat (9) @(posedge clk);
    @(negedge clk);
    check_reset_values();
    if (errors == 0) begin
      n_pass++;
    end else begin
      n_fail++;
    end
    $display("reset values: %s", (errors == 0) ? "ok" : "FAILED");
    @(posedge clk);
    fsm_rst  <= 1'b0;
    counting = 1'b1;
    for (int c = 0; c < kind_q.size(); c++) begin
      errors = 0;
      if (kind_q[c] == "W") begin
        wb_access(1'b1, a_q[c][4:0], b_q[c], rdat, acked);
        model_write(a_q[c][4:0], b_q[c]);
        assert (acked) else report_problem("a write was not acknowledged");
      end else if (kind_q[c] == "R") begin
        wb_access(1'b0, a_q[c][4:0], '0, rdat, acked);
        assert (acked) else report_problem("a read was not acknowledged");
        assert (rdat === b_q[c]) else report_value("wb_dat_r", rdat, b_q[c]);
      end else begin
        run_datagram(a_q[c], b_q[c][7:0], c_q[c][7:0], d_q[c][15:0], e_q[c][15:0],
                     res_q[c]);
      end
      if (errors == 0) begin
        n_pass++;
      end else begin
        n_fail++;
      end
      $display("case %0d: %c %h %s: %s", c, kind_q[c], a_q[c], res_q[c],
               (errors == 0) ? "ok" : "FAILED");
    end
    counting = 1'b0;
    $display("%0d checks passed, %0d failed", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- ipv4_tx.f
rtl/ipv4_tx_pkg.sv
rtl/addr_resolver.sv
rtl/ipv4_cks_calc.sv
rtl/ipv4_tx_framer.sv
rtl/ipv4_tx_top.sv
verification/ipv4_tx_tb.sv

//--- Makefile
# Verilator flow for the ipv4_tx project.
# Any variable can be overridden, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= ipv4_tx_tb
RTL_TOP   ?= ipv4_tx_top
FILELIST  ?= ipv4_tx.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing --assert
PASS_MSG  ?= Simulation passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "pass message not found in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/ipv4_tx_cases.txt
# W <addr> <data>                          wishbone write
# R <addr> <expected data>                 wishbone read
# T <dst> <proto> <ttl> <id> <pld_len> <hit|miss|broadcast>
W 00 c0a80001
W 01 ffff021a
W 02 2b3c4d5e
R 00 c0a80001
R 01 0000021a
R 02 2b3c4d5e
W 03 c0a80002
W 04 00000011
W 05 22334455
R 03 c0a80002
R 04 00000011
R 05 22334455
W 06 00000002
W 03 c0a80063
W 04 00006677
W 05 8899aabb
W 06 00000005
W 1a 12345678
R 1a 00000000
R 06 00000000
T c0a80002 11 40 1234 0010 hit
T c0a80063 06 80 0001 0000 hit
T ffffffff 11 01 abcd 0005 broadcast
T c0a80077 11 40 0002 0008 miss
T c0a80063 11 40 0003 0004 hit
W 03 c0a80002
W 04 0000dead
W 05 beef0001
W 06 00000002
T c0a80002 11 40 0004 0020 hit
W 03 ffffffff
W 04 0000aaaa
W 05 aaaaaaaa
W 06 00000007
T ffffffff 01 ff 0005 0003 broadcast
